// ==== hdl/uart_pkg.sv ====
/*
 * Shared UART definitions
 * Byte, bit counter and bit index types
 * Transmit FIFO head struct
 * Transmit and receive state enums
 */

`default_nettype none

package uart_pkg;

    // ==============================
    // Frame format
    // ==============================

    // Data bits per frame, sent LSB first
    localparam int DATA_BITS = 8;

    // ==============================
    // Types
    // ==============================

    // One data byte
    typedef logic [DATA_BITS-1:0] uart_byte_t;

    // Clock count inside one bit period
    typedef logic [15:0] baud_cnt_t;

    // Index of the current data bit
    typedef logic [2:0] bit_idx_t;

    // Oldest FIFO entry as seen by the transmitter
    typedef struct packed {
        logic       valid;
        uart_byte_t data;
    } tx_head_t;

    // Transmit FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    // Receive FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START_MID,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

`default_nettype wire

// ==== hdl/uart_tx_fifo.sv ====
/*
 * Transmit FIFO built from flip-flops
 * Circular array with read and write pointers
 * Head byte and not-empty flag presented as one struct
 */

`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_write,
    input  uart_pkg::uart_byte_t i_data,
    input  logic                 i_pop,
    output uart_pkg::tx_head_t   o_head,
    output logic                 o_full
);
    import uart_pkg::*;

    // Depth is a power of two so the pointers wrap on their own
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    uart_byte_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    // Writes while full are dropped
    assign do_push = i_write && !o_full;
    assign do_pop  = i_pop && o_head.valid;

    // Pointers and occupancy
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge i_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= i_data;
    end

    // Head is valid one cycle after the write
    assign o_head.valid = (count != '0);
    assign o_head.data  = mem[rd_ptr];
    assign o_full       = (count == (PTR_W + 1)'(FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
/*
 * UART transmitter
 * Bit timer pacing a four-state serializer
 * Start bit, eight data bits LSB first, STOP_BITS stop bits
 */

`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 16,
    parameter int STOP_BITS    = 1
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  uart_pkg::tx_head_t i_head,
    output logic               o_pop,
    output logic               o_txd
);
    import uart_pkg::*;

    localparam baud_cnt_t BIT_LAST  = baud_cnt_t'(CLKS_PER_BIT - 1);
    localparam bit_idx_t  DATA_LAST = bit_idx_t'(DATA_BITS - 1);
    localparam bit_idx_t  STOP_LAST = bit_idx_t'(STOP_BITS - 1);

    tx_state_e  tx_state;
    baud_cnt_t  baud_cnt;
    bit_idx_t   bit_idx;
    bit_idx_t   next_idx;
    uart_byte_t tx_byte;
    logic       bit_end;

    // ==============================
    // Bit timer
    // ==============================

    // Last cycle of the current bit
    assign bit_end  = (baud_cnt == BIT_LAST);
    assign next_idx = bit_idx + 1'b1;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            baud_cnt <= '0;
        else if (tx_state == TX_IDLE || bit_end)
            baud_cnt <= '0;
        else
            baud_cnt <= baud_cnt + 1'b1;
    end

    // ==============================
    // Serializer FSM
    // ==============================

    // Pop on the cycle the FSM leaves idle
    assign o_pop = (tx_state == TX_IDLE) && i_head.valid;

    always_ff @(posedge i_clk)
    begin
        if (o_pop)
            tx_byte <= i_head.data;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            tx_state <= TX_IDLE;
            bit_idx  <= '0;
            o_txd    <= 1'b1;
        end
        else
        begin
            case (tx_state)
                TX_IDLE:
                    // Line drops on the next cycle
                    if (i_head.valid)
                    begin
                        tx_state <= TX_START;
                        o_txd    <= 1'b0;
                    end
                TX_START:
                    if (bit_end)
                    begin
                        tx_state <= TX_DATA;
                        bit_idx  <= '0;
                        o_txd    <= tx_byte[0];
                    end
                TX_DATA:
                    if (bit_end)
                    begin
                        if (bit_idx == DATA_LAST)
                        begin
                            tx_state <= TX_STOP;
                            bit_idx  <= '0;
                            o_txd    <= 1'b1;
                        end
                        else
                        begin
                            bit_idx <= next_idx;
                            o_txd   <= tx_byte[next_idx];
                        end
                    end
                TX_STOP:
                    // Index reused to count stop periods
                    if (bit_end)
                    begin
                        if (bit_idx == STOP_LAST)
                            tx_state <= TX_IDLE;
                        else
                            bit_idx <= next_idx;
                    end
                default:
                begin
                    tx_state <= TX_IDLE;
                    o_txd    <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
/*
 * UART receiver
 * Five-stage input synchronizer and glitch filter
 * Start detection, mid-bit sampling and stop check
 * One-cycle byte strobe or framing-error strobe
 */

`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_rxd,
    output logic                 o_rx_valid,
    output uart_pkg::uart_byte_t o_rx_byte,
    output logic                 o_frame_err
);
    import uart_pkg::*;

    // Half a bit less the counter restart cycle
    // Start detect and sample tap both trail the pin by two cycles
    localparam baud_cnt_t HALF_LAST = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);
    localparam baud_cnt_t BIT_LAST  = baud_cnt_t'(CLKS_PER_BIT - 1);
    localparam bit_idx_t  DATA_LAST = bit_idx_t'(DATA_BITS - 1);

    rx_state_e  rx_state;
    logic [4:0] rxd_d;
    logic       rx_start;
    logic       rx_bit;
    logic       bit_end;
    baud_cnt_t  baud_cnt;
    bit_idx_t   bit_idx;
    uart_byte_t rx_byte;

    // ==============================
    // Input filter
    // ==============================

    // Newest sample in bit 0
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            rxd_d <= '1;
        else
            rxd_d <= {rxd_d[3:0], i_rxd};
    end

    // Two high samples, then two low samples three cycles later
    assign rx_start = (rxd_d[4:3] == 2'b11) && (rxd_d[1:0] == 2'b00);

    // Synchronized line level used for sampling
    assign rx_bit = rxd_d[1];

    // ==============================
    // Bit counter
    // ==============================

    // Half period before the start check, full periods after
    assign bit_end = (rx_state == RX_START_MID) ? (baud_cnt == HALF_LAST)
                                                : (baud_cnt == BIT_LAST);

    // Restarts on every state step
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            baud_cnt <= '0;
        else if (rx_state == RX_IDLE || bit_end)
            baud_cnt <= '0;
        else
            baud_cnt <= baud_cnt + 1'b1;
    end

    // ==============================
    // Receive FSM
    // ==============================

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rx_state    <= RX_IDLE;
            bit_idx     <= '0;
            o_rx_valid  <= 1'b0;
            o_frame_err <= 1'b0;
        end
        else
        begin
            o_rx_valid  <= 1'b0;
            o_frame_err <= 1'b0;
            case (rx_state)
                RX_IDLE:
                    // Start pattern needs a high line first
                    // So a held-low line never re-arms the FSM
                    if (rx_start)
                        rx_state <= RX_START_MID;
                RX_START_MID:
                    if (bit_end)
                    begin
                        // Line back high at mid-start means a glitch
                        if (!rx_bit)
                        begin
                            rx_state <= RX_DATA;
                            bit_idx  <= '0;
                        end
                        else
                            rx_state <= RX_IDLE;
                    end
                RX_DATA:
                    if (bit_end)
                    begin
                        if (bit_idx == DATA_LAST)
                            rx_state <= RX_STOP;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                RX_STOP:
                    // Middle of the first stop bit
                    if (bit_end)
                    begin
                        o_rx_valid  <= rx_bit;
                        o_frame_err <= !rx_bit;
                        rx_state    <= RX_IDLE;
                    end
                default:
                    rx_state <= RX_IDLE;
            endcase
        end
    end

    // Data enters at the top so the first bit ends in bit 0
    always_ff @(posedge i_clk)
    begin
        if (rx_state == RX_DATA && bit_end)
            rx_byte <= {rx_bit, rx_byte[DATA_BITS-1:1]};
    end

    assign o_rx_byte = rx_byte;

endmodule

`default_nettype wire

// ==== hdl/uart_core.sv ====
/*
 * UART core top level
 * Transmit FIFO feeding the transmitter
 * Independent receiver with strobe outputs
 */

`timescale 1ns/1ps
`default_nettype none

module uart_core #(
    parameter int CLKS_PER_BIT = 16,
    parameter int STOP_BITS    = 1,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_tx_write,
    input  uart_pkg::uart_byte_t i_tx_byte,
    output logic                 o_tx_full,
    output logic                 o_txd,
    input  logic                 i_rxd,
    output logic                 o_rx_valid,
    output uart_pkg::uart_byte_t o_rx_byte,
    output logic                 o_rx_frame_err
);
    import uart_pkg::*;

    // FIFO head and pop between buffer and transmitter
    tx_head_t tx_head;
    logic     tx_pop;

    // Host writes wait here
    uart_tx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uart_tx_fifo_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_write (i_tx_write),
        .i_data  (i_tx_byte),
        .i_pop   (tx_pop),
        .o_head  (tx_head),
        .o_full  (o_tx_full)
    );

    // Serial output
    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .STOP_BITS   (STOP_BITS)
    ) uart_tx_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_head  (tx_head),
        .o_pop   (tx_pop),
        .o_txd   (o_txd)
    );

    // Serial input
    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_rx_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rxd       (i_rxd),
        .o_rx_valid  (o_rx_valid),
        .o_rx_byte   (o_rx_byte),
        .o_frame_err (o_rx_frame_err)
    );

endmodule

`default_nettype wire

// ==== sim/uart_checker.sv ====
/*
 * Concurrent assertions on the UART core
 * One-cycle receive strobes, full level held while transmitting, idle line level
 * Attached to uart_core with bind
 */

`timescale 1ns/1ps
`default_nettype none

module uart_checker (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_rx_valid,
    input  logic                i_rx_frame_err,
    input  logic                i_tx_full,
    input  logic                i_txd,
    input  uart_pkg::tx_state_e i_tx_state
);
    import uart_pkg::*;

    // Count of failed assertions
    int assert_fail_count = 0;

    // Each received frame gives a single-cycle strobe
    a_rx_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rx_valid || i_rx_frame_err) |=> !(i_rx_valid || i_rx_frame_err))
    else
    begin
        $error("Receive strobe high for more than one cycle");
        assert_fail_count++;
    end

    // Full FIFO stays full until the transmitter pops
    a_full_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_tx_full && i_tx_state != TX_IDLE) |=> i_tx_full)
    else
    begin
        $error("o_tx_full dropped while the transmitter was busy");
        assert_fail_count++;
    end

    // Idle transmitter keeps the line at mark level
    a_idle_line: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_tx_state == TX_IDLE) |-> i_txd)
    else
    begin
        $error("o_txd low while the transmitter is idle");
        assert_fail_count++;
    end

endmodule

bind uart_core uart_checker uart_checker_inst (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_rx_valid     (o_rx_valid),
    .i_rx_frame_err (o_rx_frame_err),
    .i_tx_full      (o_tx_full),
    .i_txd          (o_txd),
    .i_tx_state     (uart_tx_inst.tx_state)
);

`default_nettype wire

// ==== sim/uart_monitor.sv ====
/*
 * UART reference model and scoreboard
 * Decodes o_txd cycle by cycle against the queue of accepted writes
 * Models FIFO occupancy for o_tx_full, checks receive strobes and reset values
 */

`timescale 1ns/1ps
`default_nettype none

module uart_monitor #(
    parameter int CLKS_PER_BIT = 16,
    parameter int STOP_BITS    = 1,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_tx_full,
    input  logic                 i_txd,
    input  logic                 i_rx_valid,
    input  uart_pkg::uart_byte_t i_rx_byte,
    input  logic                 i_rx_frame_err,
    output int                   o_tx_errors,
    output int                   o_rx_errors,
    output int                   o_misc_errors,
    output logic                 o_idle
);
    import uart_pkg::*;

    localparam int FRAME_CYCLES = (1 + DATA_BITS + STOP_BITS) * CLKS_PER_BIT;

    // Expected receive result
    typedef struct packed {
        logic       stop_ok;
        uart_byte_t data;
    } rx_frame_t;

    uart_byte_t tx_q [$];
    rx_frame_t  rx_q [$];
    rx_frame_t  exp_frame;
    uart_byte_t exp_byte;
    uart_byte_t got_byte;
    int         tx_errors        = 0;
    int         rx_errors        = 0;
    int         misc_errors      = 0;
    int         writes_pushed    = 0;
    int         writes_committed = 0;
    int         pops             = 0;
    int         cycle_idx        = 0;
    int         bit_pos;
    logic       exp_bit;
    logic       rst_q            = 1'b0;
    logic       post_reset       = 1'b0;
    logic       prev_txd         = 1'b1;
    logic       frame_active     = 1'b0;
    logic       frame_bad        = 1'b0;

    assign o_tx_errors   = tx_errors;
    assign o_rx_errors   = rx_errors;
    assign o_misc_errors = misc_errors;

    task report_mismatch(input string name, input logic [7:0] exp, input logic [7:0] got);
        $display("FAILED %s: expected %h got %h", name, exp, got);
    endtask

    // Called by the stimulus for every write the FIFO accepts
    task expect_tx(input uart_byte_t b);
        tx_q.push_back(b);
        writes_pushed++;
    endtask

    // Called by the serial driver as each frame starts
    task expect_rx(input uart_byte_t b, input logic stop_ok);
        rx_q.push_back({stop_ok, b});
    endtask

    // A write driven before this edge is in the FIFO after it
    always @(posedge i_clk)
    begin
        rst_q            = i_rst_n;
        writes_committed = writes_pushed;
    end

    always @(negedge i_clk)
    begin
        // ==============================
        // Reset values
        // ==============================
        if (!rst_q || post_reset)
        begin
            if (i_txd !== 1'b1)
            begin
                report_mismatch("o_txd", 8'h01, {7'b0, i_txd});
                misc_errors++;
            end
            if (i_tx_full !== 1'b0 || i_rx_valid !== 1'b0 || i_rx_frame_err !== 1'b0)
            begin
                report_mismatch("o_tx_full,o_rx_valid,o_rx_frame_err", 8'h00,
                                {5'b0, i_tx_full, i_rx_valid, i_rx_frame_err});
                misc_errors++;
            end
        end
        post_reset = !rst_q;

        if (!rst_q)
        begin
            prev_txd     = 1'b1;
            frame_active = 1'b0;
        end
        else
        begin
            // ==============================
            // Transmit frame decode
            // ==============================
            // Falling line from idle marks the start bit and the pop
            if (!frame_active && prev_txd && !i_txd)
            begin
                frame_active = 1'b1;
                frame_bad    = 1'b0;
                cycle_idx    = 0;
                got_byte     = '0;
                pops++;
                if (tx_q.size() == 0)
                begin
                    $display("o_txd started a frame with no byte written");
                    tx_errors++;
                    exp_byte = '0;
                end
                else
                    exp_byte = tx_q.pop_front();
            end

            if (frame_active)
            begin
                // Expected level for every cycle of the frame
                bit_pos = cycle_idx / CLKS_PER_BIT;
                if (bit_pos == 0)
                    exp_bit = 1'b0;
                else if (bit_pos <= DATA_BITS)
                    exp_bit = exp_byte[bit_pos-1];
                else
                    exp_bit = 1'b1;
                if (i_txd !== exp_bit && !frame_bad)
                begin
                    report_mismatch("o_txd", {7'b0, exp_bit}, {7'b0, i_txd});
                    frame_bad = 1'b1;
                    tx_errors++;
                end
                // Mid-bit sample builds the decoded byte
                if (bit_pos >= 1 && bit_pos <= DATA_BITS &&
                    cycle_idx % CLKS_PER_BIT == CLKS_PER_BIT / 2)
                    got_byte[bit_pos-1] = i_txd;
                cycle_idx++;
                if (cycle_idx == FRAME_CYCLES)
                begin
                    frame_active = 1'b0;
                    if (got_byte !== exp_byte)
                    begin
                        report_mismatch("o_txd byte", exp_byte, got_byte);
                        tx_errors++;
                    end
                end
            end
            prev_txd = i_txd;

            // FIFO occupancy model
            if (i_tx_full !== (writes_committed - pops == FIFO_DEPTH))
            begin
                report_mismatch("o_tx_full", {7'b0, writes_committed - pops == FIFO_DEPTH},
                                {7'b0, i_tx_full});
                tx_errors++;
            end

            // ==============================
            // Receive strobes
            // ==============================
            if (i_rx_valid || i_rx_frame_err)
            begin
                if (rx_q.size() == 0)
                begin
                    $display("Receive strobe with no frame driven on i_rxd");
                    rx_errors++;
                end
                else
                begin
                    exp_frame = rx_q.pop_front();
                    if (i_rx_valid !== exp_frame.stop_ok)
                    begin
                        report_mismatch("o_rx_valid", {7'b0, exp_frame.stop_ok},
                                        {7'b0, i_rx_valid});
                        rx_errors++;
                    end
                    if (i_rx_frame_err !== !exp_frame.stop_ok)
                    begin
                        report_mismatch("o_rx_frame_err", {7'b0, !exp_frame.stop_ok},
                                        {7'b0, i_rx_frame_err});
                        rx_errors++;
                    end
                    if (exp_frame.stop_ok && i_rx_byte !== exp_frame.data)
                    begin
                        report_mismatch("o_rx_byte", exp_frame.data, i_rx_byte);
                        rx_errors++;
                    end
                end
            end
        end

        o_idle = (tx_q.size() == 0) && !frame_active && (rx_q.size() == 0);
    end

endmodule

`default_nettype wire

// ==== sim/tb_uart.sv ====
/*
 * UART core testbench
 * Clock, reset, seeded random transmit bursts and serial frames
 * Glitches on the idle receive line, timeout and closing report
 */

`timescale 1ns/1ps
`default_nettype none

module tb_uart;
    import uart_pkg::*;

    localparam int CLKS_PER_BIT = 16;
    localparam int STOP_BITS    = 2;
    localparam int FIFO_DEPTH   = 16;
    localparam int N_FRAMES     = 200;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 32'hf025;

    // ==============================
    // Run length
    // ==============================
    localparam int TX_FRAME_CYCLES = (1 + DATA_BITS + STOP_BITS) * CLKS_PER_BIT;
    localparam int TX_GAP_MAX      = TX_FRAME_CYCLES;
    localparam int BURST_MAX       = FIFO_DEPTH + 4;
    // Idle, optional glitch with its recovery time, then start, data and stop
    localparam int RX_GAP_MAX      = 12 + 2 + 2 * CLKS_PER_BIT;
    localparam int RX_FRAME_CYCLES = (2 + DATA_BITS) * CLKS_PER_BIT + RX_GAP_MAX;
    // Each accepted write costs at most one burst, one gap and one frame
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + 1000
                                   + N_FRAMES * (TX_FRAME_CYCLES + 1 + TX_GAP_MAX + BURST_MAX)
                                   + N_FRAMES * RX_FRAME_CYCLES;

    logic       i_clk = 1'b0;
    logic       i_rst_n;
    logic       tx_write;
    uart_byte_t tx_byte;
    logic       tx_full;
    logic       txd;
    logic       rxd;
    logic       rx_valid;
    uart_byte_t rx_byte;
    logic       rx_frame_err;
    logic       mon_idle;
    int         tx_errors;
    int         rx_errors;
    int         misc_errors;
    int         assert_errors;
    int         cycle_count;
    int         seed_init;

    uart_core #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .STOP_BITS   (STOP_BITS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) uart_core_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_tx_write     (tx_write),
        .i_tx_byte      (tx_byte),
        .o_tx_full      (tx_full),
        .o_txd          (txd),
        .i_rxd          (rxd),
        .o_rx_valid     (rx_valid),
        .o_rx_byte      (rx_byte),
        .o_rx_frame_err (rx_frame_err)
    );

    uart_monitor #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .STOP_BITS   (STOP_BITS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) uart_monitor_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_tx_full      (tx_full),
        .i_txd          (txd),
        .i_rx_valid     (rx_valid),
        .i_rx_byte      (rx_byte),
        .i_rx_frame_err (rx_frame_err),
        .o_tx_errors    (tx_errors),
        .o_rx_errors    (rx_errors),
        .o_misc_errors  (misc_errors),
        .o_idle         (mon_idle)
    );

    // 10 ns clock
    initial
    begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // Bursts long enough to fill the FIFO
    // Writes while full are dropped
    task automatic send_tx_bursts();
        int accepted;
        int burst_len;
        int gap;
        accepted = 0;
        while (accepted < N_FRAMES)
        begin
            burst_len = $urandom_range(1, BURST_MAX);
            repeat (burst_len)
            begin
                @(negedge i_clk);
                tx_byte  = uart_byte_t'($urandom);
                tx_write = (accepted < N_FRAMES);
                // Full level is stable between rising edges
                if (tx_write && !tx_full)
                begin
                    uart_monitor_inst.expect_tx(tx_byte);
                    accepted++;
                end
            end
            @(negedge i_clk);
            tx_write = 1'b0;
            gap = $urandom_range(0, TX_GAP_MAX);
            repeat (gap) @(negedge i_clk);
        end
    endtask

    // Starts on a falling edge and ends on one
    task automatic hold_rxd(input logic level, input int cycles);
        rxd = level;
        repeat (cycles) @(negedge i_clk);
    endtask

    // Serial frames with one driven stop bit, good or low
    task automatic send_rx_frames();
        uart_byte_t data;
        logic       stop_ok;
        int         b;
        @(negedge i_clk);
        for (int i = 0; i < N_FRAMES; i++)
        begin
            data    = uart_byte_t'($urandom);
            stop_ok = ($urandom_range(0, 4) != 0);
            hold_rxd(1'b1, $urandom_range(4, 12));
            // Short low glitch, then a full bit of idle so it dies out
            if ($urandom_range(0, 1) == 1)
            begin
                hold_rxd(1'b0, $urandom_range(1, 2));
                hold_rxd(1'b1, CLKS_PER_BIT + $urandom_range(0, CLKS_PER_BIT));
            end
            uart_monitor_inst.expect_rx(data, stop_ok);
            hold_rxd(1'b0, CLKS_PER_BIT);
            for (b = 0; b < DATA_BITS; b++)
                hold_rxd(data[b], CLKS_PER_BIT);
            hold_rxd(stop_ok, CLKS_PER_BIT);
        end
        rxd = 1'b1;
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial
    begin
        seed_init = $urandom(SEED);
        i_rst_n   = 1'b0;
        tx_write  = 1'b0;
        tx_byte   = '0;
        rxd       = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        repeat (2) @(negedge i_clk);

        fork
            send_tx_bursts();
            send_rx_frames();
        join

        // Let the FIFO drain and catch any stray strobe
        while (!mon_idle)
            @(posedge i_clk);
        repeat (4 * CLKS_PER_BIT) @(negedge i_clk);

        assert_errors = uart_core_inst.uart_checker_inst.assert_fail_count;
        $display("Error counts: transmit %0d, receive %0d, other %0d, assertions %0d",
                 tx_errors, rx_errors, misc_errors, assert_errors);
        if (tx_errors + rx_errors + misc_errors + assert_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog
    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("Timeout, traffic did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/uart_pkg.sv
hdl/uart_tx_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_core.sv
sim/uart_checker.sv
sim/uart_monitor.sv
sim/tb_uart.sv

// ==== Bender.yml ====
package:
  name: uart_core

sources:
  - hdl/uart_pkg.sv
  - hdl/uart_tx_fifo.sv
  - hdl/uart_tx.sv
  - hdl/uart_rx.sv
  - hdl/uart_core.sv
  - target: simulation
    files:
      - sim/uart_checker.sv
      - sim/uart_monitor.sv
      - sim/tb_uart.sv
